//--- include/core_defines.svh
// Width and reset-value macros for the integer pipeline, included ahead of packages and stages
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

//////////////////////////////////////////////////
// Datapath sizing
//////////////////////////////////////////////////

// Data and PC width
`define XLEN_W 32

// Register index width, five bits for x0..x31
`define REG_ADDR_W 5

// Architectural integer registers, x0 included
`define NUM_REGS 32

//////////////////////////////////////////////////
// Reset values
//////////////////////////////////////////////////

// Pipeline payload and register file contents
`define DATA_RST_VAL {`XLEN_W{1'b0}}

// Destination index in pipeline registers
`define ADDR_RST_VAL {`REG_ADDR_W{1'b0}}

// Strobes and write enables
`define CTRL_RST_VAL 1'b0

`endif

//--- rtl/isa_pkg.sv
// Instruction-set encodings for the supported RV32I integer ops, imported by the decoder
`include "core_defines.svh"

package isa_pkg;

  //////////////////////////////////////////////////
  // Major opcodes
  //////////////////////////////////////////////////

  // Only the ALU-type opcodes are kept
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111
  } opcode_e;

  // funct3 selects the ALU function
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct7 values, bit 5 marks SUB and arithmetic shift
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // R-type field layout, MSB first
  typedef struct packed {
    logic [6:0]             funct7;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [`REG_ADDR_W-1:0] rd;
    opcode_e                opcode;
  } instr_t;

endpackage

//--- rtl/pipe_pkg.sv
// Micro-architecture types shared by the pipeline stages: ALU ops, operand selects, bypass bus
`include "core_defines.svh"

package pipe_pkg;

  //////////////////////////////////////////////////
  // ALU control
  //////////////////////////////////////////////////

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLT  = 4'd5,
    ALU_SLTU = 4'd6,
    ALU_SLL  = 4'd7,
    ALU_SRL  = 4'd8,
    ALU_SRA  = 4'd9
  } alu_op_e;

  // Operand A source
  // PC for AUIPC, zero for LUI
  typedef enum logic [1:0] {
    OP_A_REG  = 2'd0,
    OP_A_PC   = 2'd1,
    OP_A_ZERO = 2'd2
  } op_a_sel_e;

  // Operand B source
  typedef enum logic {
    OP_B_REG = 1'b0,
    OP_B_IMM = 1'b1
  } op_b_sel_e;

  //////////////////////////////////////////////////
  // Bypass bus
  //////////////////////////////////////////////////

  // One in-flight result offered back to decode
  // valid already includes the write enable
  typedef struct packed {
    logic                   valid;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN_W-1:0]     data;
  } fwd_t;

endpackage

//--- rtl/id_ex_if.sv
// Decoded instruction bundle passed from decode to execute
`timescale 1ns/1ps
`include "core_defines.svh"

interface id_ex_if
  import pipe_pkg::*;
();

  // One-cycle strobe per issued instruction
  logic                   valid;
  alu_op_e                alu_op;
  logic [`XLEN_W-1:0]     operand_a;
  logic [`XLEN_W-1:0]     operand_b;
  logic [`REG_ADDR_W-1:0] rd;
  logic                   we;

  // Decode side
  modport decode (output valid, alu_op, operand_a, operand_b, rd, we);

  // Execute side
  modport execute (input valid, alu_op, operand_a, operand_b, rd, we);

endinterface

//--- rtl/ex_wb_if.sv
// Executed result bundle passed from execute to the result stage
`timescale 1ns/1ps
`include "core_defines.svh"

interface ex_wb_if ();

  // High for one cycle per result
  logic                   valid;
  logic [`REG_ADDR_W-1:0] rd;
  logic [`XLEN_W-1:0]     data;
  logic                   we;

  // Execute side
  modport execute (output valid, rd, data, we);

  // Result side
  modport result (input valid, rd, data, we);

endinterface

//--- rtl/decode_stage.sv
// Decode stage: field split, immediates, EX/WB bypass, operand muxes and ID/EX register
`timescale 1ns/1ps
`include "core_defines.svh"

module decode_stage
  import isa_pkg::*, pipe_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   instr_valid_i,
  input  instr_t                 instr_i,
  input  logic [`XLEN_W-1:0]     pc_i,
  output logic [`REG_ADDR_W-1:0] rs1_addr_o,
  output logic [`REG_ADDR_W-1:0] rs2_addr_o,
  input  logic [`XLEN_W-1:0]     rs1_data_i,
  input  logic [`XLEN_W-1:0]     rs2_data_i,
  input  fwd_t                   fwd_ex_i,
  input  fwd_t                   fwd_res_i,
  id_ex_if.decode                id_ex
);

  logic [`XLEN_W-1:0] instr_bits;
  logic [`XLEN_W-1:0] imm_i;
  logic [`XLEN_W-1:0] imm_u;
  logic [`XLEN_W-1:0] imm_shamt;
  logic [`XLEN_W-1:0] imm_b;
  logic [`XLEN_W-1:0] rs1_fwd;
  logic [`XLEN_W-1:0] rs2_fwd;
  logic [`XLEN_W-1:0] operand_a;
  logic [`XLEN_W-1:0] operand_b;
  logic               legal;
  logic               we;
  logic               is_shift;
  alu_op_e            alu_op;
  op_a_sel_e          op_a_sel;
  op_b_sel_e          op_b_sel;

  // funct3 to ALU op, alt is instr bit 30
  function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
    case (f3)
      F3_ADD_SUB: return alt ? ALU_SUB : ALU_ADD;
      F3_SLL:     return ALU_SLL;
      F3_SLT:     return ALU_SLT;
      F3_SLTU:    return ALU_SLTU;
      F3_XOR:     return ALU_XOR;
      F3_SRL_SRA: return alt ? ALU_SRA : ALU_SRL;
      F3_OR:      return ALU_OR;
      F3_AND:     return ALU_AND;
    endcase
  endfunction

  // Bypass select, execute beats result beats register file
  function automatic logic [`XLEN_W-1:0] fwd_pick(
    input logic [`REG_ADDR_W-1:0] addr,
    input logic [`XLEN_W-1:0]     rf_data,
    input fwd_t                   ex_src,
    input fwd_t                   res_src
  );
    if (addr != '0 && ex_src.valid && ex_src.rd == addr)
      return ex_src.data;
    else if (addr != '0 && res_src.valid && res_src.rd == addr)
      return res_src.data;
    else
      return rf_data;
  endfunction

  //////////////////////////////////////////////////
  // Fields and immediates
  //////////////////////////////////////////////////

  assign instr_bits = instr_i;
  assign rs1_addr_o = instr_i.rs1;
  assign rs2_addr_o = instr_i.rs2;

  // I-type, sign extended from bit 31
  assign imm_i     = {{20{instr_bits[31]}}, instr_bits[31:20]};
  // U-type, low 12 bits zero
  assign imm_u     = {instr_bits[31:12], 12'b0};
  // Shift amount only, funct7 stripped
  assign imm_shamt = {27'b0, instr_bits[24:20]};

  assign is_shift = (instr_i.funct3 == F3_SLL) || (instr_i.funct3 == F3_SRL_SRA);

  // Opcode decode
  always_comb
  begin
    legal    = 1'b0;
    we       = 1'b0;
    alu_op   = ALU_ADD;
    op_a_sel = OP_A_REG;
    op_b_sel = OP_B_IMM;
    imm_b    = imm_i;
    case (instr_i.opcode)
      OPC_OP:
      begin
        op_b_sel = OP_B_REG;
        alu_op   = alu_from_funct3(instr_i.funct3, instr_i.funct7[5]);
        // Alt funct7 only on SUB and SRA
        legal    = (instr_i.funct7 == F7_BASE) ||
                   ((instr_i.funct7 == F7_ALT) &&
                    ((instr_i.funct3 == F3_ADD_SUB) || (instr_i.funct3 == F3_SRL_SRA)));
        we       = 1'b1;
      end
      OPC_OP_IMM:
      begin
        // Bit 30 is immediate data except on shifts
        alu_op = alu_from_funct3(instr_i.funct3,
                                 instr_i.funct7[5] && (instr_i.funct3 == F3_SRL_SRA));
        imm_b  = is_shift ? imm_shamt : imm_i;
        legal  = !is_shift || (instr_i.funct7 == F7_BASE) ||
                 ((instr_i.funct7 == F7_ALT) && (instr_i.funct3 == F3_SRL_SRA));
        we     = 1'b1;
      end
      OPC_LUI:
      begin
        op_a_sel = OP_A_ZERO;
        imm_b    = imm_u;
        legal    = 1'b1;
        we       = 1'b1;
      end
      OPC_AUIPC:
      begin
        op_a_sel = OP_A_PC;
        imm_b    = imm_u;
        legal    = 1'b1;
        we       = 1'b1;
      end
      // Anything else is dropped, no strobe
      default:
      begin
        legal = 1'b0;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Bypass and operand muxes
  //////////////////////////////////////////////////

  assign rs1_fwd = fwd_pick(instr_i.rs1, rs1_data_i, fwd_ex_i, fwd_res_i);
  assign rs2_fwd = fwd_pick(instr_i.rs2, rs2_data_i, fwd_ex_i, fwd_res_i);

  always_comb
  begin
    case (op_a_sel)
      OP_A_PC:   operand_a = pc_i;
      OP_A_ZERO: operand_a = '0;
      default:   operand_a = rs1_fwd;
    endcase
  end

  assign operand_b = (op_b_sel == OP_B_REG) ? rs2_fwd : imm_b;

  //////////////////////////////////////////////////
  // ID/EX register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      id_ex.valid     <= `CTRL_RST_VAL;
      id_ex.alu_op    <= ALU_ADD;
      id_ex.operand_a <= `DATA_RST_VAL;
      id_ex.operand_b <= `DATA_RST_VAL;
      id_ex.rd        <= `ADDR_RST_VAL;
      id_ex.we        <= `CTRL_RST_VAL;
    end
    else
    begin
      // Illegal ops never reach execute
      id_ex.valid <= instr_valid_i & legal;
      if (instr_valid_i)
      begin
        id_ex.alu_op    <= alu_op;
        id_ex.operand_a <= operand_a;
        id_ex.operand_b <= operand_b;
        id_ex.rd        <= instr_i.rd;
        id_ex.we        <= we;
      end
    end
  end

endmodule

//--- rtl/execute_stage.sv
// Execute stage: integer ALU, bypass source for decode and the EX/result register
`timescale 1ns/1ps
`include "core_defines.svh"

module execute_stage
  import pipe_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  id_ex_if.execute  id_ex,
  ex_wb_if.execute  ex_wb,
  output fwd_t      fwd_ex_o
);

  logic [`XLEN_W-1:0] alu_result;
  logic [4:0]         shamt;

  // Shifts only look at the low five bits of B
  assign shamt = id_ex.operand_b[4:0];

  //////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////

  always_comb
  begin
    case (id_ex.alu_op)
      ALU_ADD:  alu_result = id_ex.operand_a + id_ex.operand_b;
      ALU_SUB:  alu_result = id_ex.operand_a - id_ex.operand_b;
      ALU_AND:  alu_result = id_ex.operand_a & id_ex.operand_b;
      ALU_OR:   alu_result = id_ex.operand_a | id_ex.operand_b;
      ALU_XOR:  alu_result = id_ex.operand_a ^ id_ex.operand_b;
      // Compares give 0 or 1
      ALU_SLT:
      begin
        alu_result = {31'b0, $signed(id_ex.operand_a) < $signed(id_ex.operand_b)};
      end
      ALU_SLTU:
      begin
        alu_result = {31'b0, id_ex.operand_a < id_ex.operand_b};
      end
      ALU_SLL:  alu_result = id_ex.operand_a << shamt;
      ALU_SRL:  alu_result = id_ex.operand_a >> shamt;
      // Sign bit fills from the left
      ALU_SRA:  alu_result = $unsigned($signed(id_ex.operand_a) >>> shamt);
      default:  alu_result = '0;
    endcase
  end

  // Youngest bypass source, still combinational
  assign fwd_ex_o.valid = id_ex.valid & id_ex.we;
  assign fwd_ex_o.rd    = id_ex.rd;
  assign fwd_ex_o.data  = alu_result;

  //////////////////////////////////////////////////
  // EX/result register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ex_wb.valid <= `CTRL_RST_VAL;
      ex_wb.rd    <= `ADDR_RST_VAL;
      ex_wb.data  <= `DATA_RST_VAL;
      ex_wb.we    <= `CTRL_RST_VAL;
    end
    else
    begin
      ex_wb.valid <= id_ex.valid;
      // Payload held between results
      if (id_ex.valid)
      begin
        ex_wb.rd   <= id_ex.rd;
        ex_wb.data <= alu_result;
        ex_wb.we   <= id_ex.we;
      end
    end
  end

endmodule

//--- rtl/result_stage.sv
// Result stage: integer register file, x0 handling, older bypass source and result outputs
`timescale 1ns/1ps
`include "core_defines.svh"

module result_stage
  import pipe_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  ex_wb_if.result                ex_wb,
  input  logic [`REG_ADDR_W-1:0] rs1_addr_i,
  input  logic [`REG_ADDR_W-1:0] rs2_addr_i,
  output logic [`XLEN_W-1:0]     rs1_data_o,
  output logic [`XLEN_W-1:0]     rs2_data_o,
  output fwd_t                   fwd_res_o,
  output logic                   result_valid_o,
  output logic [`REG_ADDR_W-1:0] result_rd_o,
  output logic [`XLEN_W-1:0]     result_data_o
);

  // x0 has no storage
  logic [`XLEN_W-1:0] regs [1:`NUM_REGS-1];
  logic               wr_en;

  //////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////

  // Writes to x0 are dropped here only
  assign wr_en = ex_wb.valid & ex_wb.we & (ex_wb.rd != '0);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 1; i < `NUM_REGS; i++)
      begin
        regs[i] <= `DATA_RST_VAL;
      end
    end
    else if (wr_en)
    begin
      regs[ex_wb.rd] <= ex_wb.data;
    end
  end

  // Asynchronous reads, x0 hardwired to zero
  // Same-cycle write is covered by the bypass in decode
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

  //////////////////////////////////////////////////
  // Bypass and result ports
  //////////////////////////////////////////////////

  // One stage older than the execute source
  assign fwd_res_o.valid = ex_wb.valid & ex_wb.we;
  assign fwd_res_o.rd    = ex_wb.rd;
  assign fwd_res_o.data  = ex_wb.data;

  // Strobe shows x0 writes too
  assign result_valid_o = ex_wb.valid;
  assign result_rd_o    = ex_wb.rd;
  assign result_data_o  = ex_wb.data;

endmodule

//--- rtl/int_pipe_top.sv
// Top level of the three-stage integer pipeline, plain ports toward the testbench
`timescale 1ns/1ps
`include "core_defines.svh"

module int_pipe_top
  import pipe_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   instr_valid_i,
  input  logic [`XLEN_W-1:0]     instr_i,
  input  logic [`XLEN_W-1:0]     pc_i,
  output logic                   result_valid_o,
  output logic [`REG_ADDR_W-1:0] result_rd_o,
  output logic [`XLEN_W-1:0]     result_data_o
);

  // Register read path
  logic [`REG_ADDR_W-1:0] rs1_addr;
  logic [`REG_ADDR_W-1:0] rs2_addr;
  logic [`XLEN_W-1:0]     rs1_data;
  logic [`XLEN_W-1:0]     rs2_data;

  // Bypass sources back to decode
  fwd_t fwd_ex;
  fwd_t fwd_res;

  // Stage links
  id_ex_if id_ex_bus ();
  ex_wb_if ex_wb_bus ();

  decode_stage u_decode (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .rs1_addr_o    (rs1_addr),
    .rs2_addr_o    (rs2_addr),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .fwd_ex_i      (fwd_ex),
    .fwd_res_i     (fwd_res),
    .id_ex         (id_ex_bus.decode)
  );

  execute_stage u_execute (
    .clk      (clk),
    .rst_n    (rst_n),
    .id_ex    (id_ex_bus.execute),
    .ex_wb    (ex_wb_bus.execute),
    .fwd_ex_o (fwd_ex)
  );

  result_stage u_result (
    .clk            (clk),
    .rst_n          (rst_n),
    .ex_wb          (ex_wb_bus.result),
    .rs1_addr_i     (rs1_addr),
    .rs2_addr_i     (rs2_addr),
    .rs1_data_o     (rs1_data),
    .rs2_data_o     (rs2_data),
    .fwd_res_o      (fwd_res),
    .result_valid_o (result_valid_o),
    .result_rd_o    (result_rd_o),
    .result_data_o  (result_data_o)
  );

endmodule

//--- tests/tb_vectors.svh
// Stimulus and expected-result table for the pipeline testbench, included inside its module
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam int NUM_ROWS = 38;

// One issued instruction and what the pipeline should return for it
typedef struct packed {
  logic [7:0]  idle;
  logic [31:0] instr;
  logic [31:0] pc;
  logic        exp_valid;
  logic [4:0]  rd;
  logic [31:0] data;
} row_t;

row_t vec [NUM_ROWS];

// R-type word, OP major opcode
function automatic logic [31:0] enc_r(input int f7, input int rs2, input int rs1,
                                      input int f3, input int rd);
  return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'h33};
endfunction

// I-type word, OP-IMM major opcode, shifts pass funct7 in the upper immediate bits
function automatic logic [31:0] enc_i(input int imm, input int rs1, input int f3, input int rd);
  return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), 7'h13};
endfunction

// U-type word for LUI or AUIPC
function automatic logic [31:0] enc_u(input int imm, input int rd, input logic [6:0] opc);
  return {20'(imm), 5'(rd), opc};
endfunction

function automatic row_t make_row(input int idle, input logic [31:0] instr,
                                  input logic [31:0] pc, input logic exp_valid,
                                  input int rd, input logic [31:0] data);
  row_t r;
  r.idle      = 8'(idle);
  r.instr     = instr;
  r.pc        = pc;
  r.exp_valid = exp_valid;
  r.rd        = 5'(rd);
  r.data      = data;
  return r;
endfunction

task automatic load_vectors();
  // First op after reset, all registers still zero
  vec[0]  = make_row(2, enc_r('h00, 2, 1, 0, 3), 32'h0, 1'b1, 3, 32'h0000_0000);
  // Immediate forms, x1 = -5 and x2 = 0x5a5
  vec[1]  = make_row(0, enc_i(-5, 0, 0, 1), 32'h0, 1'b1, 1, 32'hffff_fffb);
  vec[2]  = make_row(3, enc_i('h5a5, 0, 0, 2), 32'h0, 1'b1, 2, 32'h0000_05a5);
  vec[3]  = make_row(2, enc_i('h0f0, 2, 7, 4), 32'h0, 1'b1, 4, 32'h0000_00a0);
  vec[4]  = make_row(0, enc_i('h00a, 2, 6, 5), 32'h0, 1'b1, 5, 32'h0000_05af);
  vec[5]  = make_row(0, enc_i(-1, 2, 4, 6), 32'h0, 1'b1, 6, 32'hffff_fa5a);
  vec[6]  = make_row(0, enc_i(-4, 1, 2, 7), 32'h0, 1'b1, 7, 32'h0000_0001);
  vec[7]  = make_row(0, enc_i('h004, 2, 1, 8), 32'h0, 1'b1, 8, 32'h0000_5a50);
  vec[8]  = make_row(0, enc_i('h01c, 1, 5, 9), 32'h0, 1'b1, 9, 32'h0000_000f);
  vec[9]  = make_row(0, enc_i('h401, 1, 5, 10), 32'h0, 1'b1, 10, 32'hffff_fffd);
  vec[10] = make_row(0, enc_u('h12345, 11, 7'h37), 32'h0, 1'b1, 11, 32'h1234_5000);
  vec[11] = make_row(0, enc_u('h00010, 12, 7'h17), 32'h100, 1'b1, 12, 32'h0001_0100);
  // Register forms
  vec[12] = make_row(3, enc_r('h00, 2, 1, 0, 13), 32'h0, 1'b1, 13, 32'h0000_05a0);
  vec[13] = make_row(0, enc_r('h20, 1, 2, 0, 14), 32'h0, 1'b1, 14, 32'h0000_05aa);
  vec[14] = make_row(0, enc_r('h00, 2, 1, 7, 15), 32'h0, 1'b1, 15, 32'h0000_05a1);
  vec[15] = make_row(0, enc_r('h00, 2, 1, 6, 16), 32'h0, 1'b1, 16, 32'hffff_ffff);
  vec[16] = make_row(0, enc_r('h00, 2, 1, 4, 17), 32'h0, 1'b1, 17, 32'hffff_fa5e);
  vec[17] = make_row(0, enc_r('h00, 2, 1, 2, 18), 32'h0, 1'b1, 18, 32'h0000_0001);
  vec[18] = make_row(0, enc_r('h00, 2, 1, 3, 19), 32'h0, 1'b1, 19, 32'h0000_0000);
  vec[19] = make_row(0, enc_r('h00, 7, 2, 1, 20), 32'h0, 1'b1, 20, 32'h0000_0b4a);
  vec[20] = make_row(0, enc_r('h00, 8, 1, 5, 21), 32'h0, 1'b1, 21, 32'h0000_ffff);
  vec[21] = make_row(0, enc_r('h20, 9, 1, 5, 22), 32'h0, 1'b1, 22, 32'hffff_ffff);
  // Bypass, one source from execute and one from result
  vec[22] = make_row(3, enc_i(100, 0, 0, 23), 32'h0, 1'b1, 23, 32'h0000_0064);
  vec[23] = make_row(0, enc_i('h123, 0, 0, 24), 32'h0, 1'b1, 24, 32'h0000_0123);
  vec[24] = make_row(0, enc_r('h00, 24, 23, 0, 25), 32'h0, 1'b1, 25, 32'h0000_0187);
  vec[25] = make_row(1, enc_r('h20, 23, 25, 0, 26), 32'h0, 1'b1, 26, 32'h0000_0123);
  vec[26] = make_row(2, enc_i(5, 26, 0, 27), 32'h0, 1'b1, 27, 32'h0000_0128);
  // Two writes to x28 in flight, the younger one must win
  vec[27] = make_row(3, enc_i(7, 0, 0, 28), 32'h0, 1'b1, 28, 32'h0000_0007);
  vec[28] = make_row(0, enc_i(9, 0, 0, 28), 32'h0, 1'b1, 28, 32'h0000_0009);
  vec[29] = make_row(0, enc_i(0, 28, 0, 29), 32'h0, 1'b1, 29, 32'h0000_0009);
  // x0 write still strobes, no bypass and no storage
  vec[30] = make_row(0, enc_i('h55, 0, 0, 0), 32'h0, 1'b1, 0, 32'h0000_0055);
  vec[31] = make_row(0, enc_r('h00, 1, 0, 0, 30), 32'h0, 1'b1, 30, 32'hffff_fffb);
  vec[32] = make_row(3, enc_i(3, 0, 0, 31), 32'h0, 1'b1, 31, 32'h0000_0003);
  // Load and MUL are unsupported, no strobe
  vec[33] = make_row(0, 32'h0000_a083, 32'h0, 1'b0, 0, 32'h0);
  vec[34] = make_row(0, enc_i(1, 31, 0, 1), 32'h0, 1'b1, 1, 32'h0000_0004);
  vec[35] = make_row(0, enc_r('h01, 1, 1, 0, 1), 32'h0, 1'b0, 0, 32'h0);
  vec[36] = make_row(0, enc_r('h00, 1, 1, 0, 2), 32'h0, 1'b1, 2, 32'h0000_0008);
  // Isolated issue at the end
  vec[37] = make_row(4, enc_r('h00, 0, 2, 0, 3), 32'h0, 1'b1, 3, 32'h0000_0008);
endtask

`endif

//--- tests/tb_int_pipe.sv
// Testbench for int_pipe_top, issues the vector table and checks every result strobe
`timescale 1ns/1ps
`include "core_defines.svh"

module tb_int_pipe;

  `include "tb_vectors.svh"

  // Result still owed by the pipeline
  typedef struct packed {
    logic [4:0]  rd;
    logic [31:0] data;
    logic [31:0] due;
  } exp_t;

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   instr_valid_i;
  logic [`XLEN_W-1:0]     instr_i;
  logic [`XLEN_W-1:0]     pc_i;
  logic                   result_valid_o;
  logic [`REG_ADDR_W-1:0] result_rd_o;
  logic [`XLEN_W-1:0]     result_data_o;

  exp_t pending [$];
  exp_t seen;
  int   errors;
  int   checks;
  int   cycle_count;
  int   timeout_limit;

  int_pipe_top dut_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .pc_i           (pc_i),
    .result_valid_o (result_valid_o),
    .result_rd_o    (result_rd_o),
    .result_data_o  (result_data_o)
  );

  // 20 ns period
  always #10 clk = ~clk;

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  //////////////////////////////////////////////////
  // Cycle count and timeout
  //////////////////////////////////////////////////

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= timeout_limit)
    begin
      $display("timeout after %0d cycles, %0d results still outstanding",
               cycle_count, pending.size());
      $display("checks run: %0d, errors: %0d", checks, errors + 1);
      $display("TESTS FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Result monitor
  //////////////////////////////////////////////////

  // Sampled mid-cycle, outputs only move at the rising edge
  always @(negedge clk)
  begin
    if (result_valid_o === 1'b1)
    begin
      if (pending.size() == 0)
      begin
        errors++;
        $display("result strobe for x%0d at %0t with no instruction pending",
                 result_rd_o, $time);
      end
      else
      begin
        seen = pending.pop_front();
        check_value("result rd", {27'b0, result_rd_o}, {27'b0, seen.rd});
        check_value("result data", result_data_o, seen.data);
        // Strobe two edges after the issue edge
        check_value("result cycle", cycle_count, seen.due);
      end
    end
    else if (result_valid_o !== 1'b0)
    begin
      errors++;
      $display("result_valid_o is unknown at %0t", $time);
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial
  begin
    exp_t entry;
    int   drain;
    errors        = 0;
    checks        = 0;
    cycle_count   = 0;
    rst_n         = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    pc_i          = '0;
    load_vectors();

    // Budget from table length and idle gaps
    timeout_limit = 4 * NUM_ROWS + 50;
    for (int i = 0; i < NUM_ROWS; i++)
    begin
      timeout_limit = timeout_limit + int'(vec[i].idle);
    end

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < NUM_ROWS; i++)
    begin
      repeat (vec[i].idle)
      begin
        @(negedge clk);
        instr_valid_i = 1'b0;
      end
      @(negedge clk);
      instr_valid_i = 1'b1;
      instr_i       = vec[i].instr;
      pc_i          = vec[i].pc;
      if (vec[i].exp_valid)
      begin
        entry.rd   = vec[i].rd;
        entry.data = vec[i].data;
        entry.due  = cycle_count + 2;
        pending.push_back(entry);
      end
    end
    @(negedge clk);
    instr_valid_i = 1'b0;

    // Let the last results drain, then watch for stray strobes
    drain = 0;
    while (pending.size() != 0 && drain < 10)
    begin
      @(negedge clk);
      drain++;
    end
    repeat (3) @(negedge clk);

    if (pending.size() != 0)
    begin
      $display("%0d expected results never appeared", pending.size());
      errors = errors + pending.size();
    end

    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- flist.f
+incdir+include
+incdir+tests
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/id_ex_if.sv
rtl/ex_wb_if.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/result_stage.sv
rtl/int_pipe_top.sv
tests/tb_int_pipe.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing
TOP       := tb_int_pipe
FLIST     := flist.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
